// ==== rtl/fir_config.svh ====
/* fir filter sizes and coefficients */

`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// sample and coefficient widths
`define FIR_DATA_W  12
`define FIR_COE_W   12          // also the multiplier stage count

// pre-add sum, product and filter output widths
`define FIR_PAIR_W  (`FIR_DATA_W + 1)
`define FIR_PROD_W  (`FIR_PAIR_W + `FIR_COE_W)
`define FIR_OUT_W   29

`define FIR_TAPS    16
`define FIR_PAIRS   8           // taps folded by symmetry

// low-pass coefficients of pairs 0 to 7, sum 1049
`define FIR_COE_0   12'd11
`define FIR_COE_1   12'd31
`define FIR_COE_2   12'd63
`define FIR_COE_3   12'd104
`define FIR_COE_4   12'd152
`define FIR_COE_5   12'd198
`define FIR_COE_6   12'd235
`define FIR_COE_7   12'd255

`endif

// ==== rtl/fir_pkg.sv ====
/* fir filter types */

`include "fir_config.svh"

package fir_pkg;

    typedef logic [`FIR_DATA_W-1:0] fir_x_t;    // one input sample
    typedef logic [`FIR_PAIR_W-1:0] fir_pair_t; // sum of two mirrored samples
    typedef logic [`FIR_PROD_W-1:0] fir_prod_t; // pair sum times coefficient
    typedef logic [`FIR_OUT_W-1:0]  fir_y_t;    // filter output

    // tap line to multipliers
    typedef struct packed {
        logic                            valid;
        fir_pair_t [`FIR_PAIRS-1:0]      pair;
    } fir_pairs_t;

    // multipliers to adder tree
    typedef struct packed {
        logic                            valid;
        fir_prod_t [`FIR_PAIRS-1:0]      prod;
    } fir_prods_t;

endpackage

// ==== rtl/mult_man.sv ====
/* pipelined constant shift-add multiplier */

`timescale 1ns/10ps

module mult_man #(
    parameter int             M_W = 13,     // multiplicand width
    parameter int             C_W = 12,     // coefficient width and stage count
    parameter logic [C_W-1:0] COE = '0
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               data_rdy,
    input  logic [M_W-1:0]     mult1,
    output logic               res_rdy,
    output logic [M_W+C_W-1:0] res
);

    localparam int P_W = M_W + C_W;

    logic [C_W-1:0] rdy_q;              // one valid bit per stage
    logic [P_W-1:0] acc_q [C_W];        // partial sums over coefficient bits 0..k
    logic [P_W-1:0] mlt_q [C_W-1];      // mlt_q[k] is mult1 shifted left by k+1

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy_q <= '0;
        end else begin
            rdy_q <= {rdy_q[C_W-2:0], data_rdy};
        end
    end

    always_ff @(posedge clk) begin
        // stage 0 takes the operand straight from the input
        if (data_rdy) begin
            acc_q[0] <= COE[0] ? P_W'(mult1) : '0;
            mlt_q[0] <= P_W'(mult1) << 1;
        end
        // stage k adds the shifted operand when coefficient bit k is set
        for (int k = 1; k < C_W; k++) begin
            if (rdy_q[k-1]) begin
                acc_q[k] <= acc_q[k-1] + (COE[k] ? mlt_q[k-1] : '0);
            end
        end
        // the last stage needs no shifted copy
        for (int k = 1; k < C_W - 1; k++) begin
            if (rdy_q[k-1]) begin
                mlt_q[k] <= mlt_q[k-1] << 1;
            end
        end
    end

    assign res_rdy = rdy_q[C_W-1];
    assign res     = acc_q[C_W-1];

endmodule

// ==== rtl/fir_tap_line.sv ====
/* fir delay line and symmetric pre-add */

`timescale 1ns/10ps

`include "fir_config.svh"

module fir_tap_line
    import fir_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       en,
    input  fir_x_t     xin,
    output fir_pairs_t pairs
);

    fir_x_t                     line [`FIR_TAPS];   // line[0] is the newest sample
    logic                       en_d;
    logic                       pair_vld;
    fir_pair_t [`FIR_PAIRS-1:0] pair_q;

    // shift register, cleared so early outputs see zero history
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `FIR_TAPS; i++) begin
                line[i] <= '0;
            end
        end else if (en) begin
            line[0] <= xin;
            for (int i = 1; i < `FIR_TAPS; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            en_d     <= 1'b0;
            pair_vld <= 1'b0;
        end else begin
            en_d     <= en;
            pair_vld <= en_d;   // pair sums valid one cycle after the shift
        end
    end

    // fold tap i onto tap 15-i, one extra bit keeps the carry
    always_ff @(posedge clk) begin
        if (en_d) begin
            for (int i = 0; i < `FIR_PAIRS; i++) begin
                pair_q[i] <= fir_pair_t'(line[i]) + fir_pair_t'(line[`FIR_TAPS-1-i]);
            end
        end
    end

    assign pairs = '{valid: pair_vld, pair: pair_q};

endmodule

// ==== rtl/fir_sum_tree.sv ====
/* two-stage product adder tree */

`timescale 1ns/10ps

module fir_sum_tree
    import fir_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  fir_prods_t prods,
    output logic       valid,
    output fir_y_t     yout
);

    fir_y_t half_lo;    // products 0 to 3
    fir_y_t half_hi;    // products 4 to 7
    logic   half_vld;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            half_vld <= 1'b0;
            valid    <= 1'b0;
        end else begin
            half_vld <= prods.valid;
            valid    <= half_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (prods.valid) begin
            half_lo <= fir_y_t'(prods.prod[0]) + fir_y_t'(prods.prod[1])
                     + fir_y_t'(prods.prod[2]) + fir_y_t'(prods.prod[3]);
            half_hi <= fir_y_t'(prods.prod[4]) + fir_y_t'(prods.prod[5])
                     + fir_y_t'(prods.prod[6]) + fir_y_t'(prods.prod[7]);
        end
    end

    // output holds until the next result
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            yout <= '0;
        end else if (half_vld) begin
            yout <= half_lo + half_hi;
        end
    end

endmodule

// ==== rtl/fir_guide.sv ====
/* 16-tap symmetric low-pass fir */

`timescale 1ns/10ps

`include "fir_config.svh"

module fir_guide
    import fir_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   en,
    input  fir_x_t xin,
    output logic   valid,
    output fir_y_t yout
);

    localparam logic [`FIR_COE_W-1:0] COE_TAB [`FIR_PAIRS] = '{
        `FIR_COE_0, `FIR_COE_1, `FIR_COE_2, `FIR_COE_3,
        `FIR_COE_4, `FIR_COE_5, `FIR_COE_6, `FIR_COE_7
    };

    fir_pairs_t                 pairs;
    fir_prods_t                 prods;
    fir_prod_t [`FIR_PAIRS-1:0] prod_w;
    logic                       prod_rdy;     // lane 0 stands for all lanes

    fir_tap_line u_tap_line (
        .clk   (clk),
        .rstn  (rstn),
        .en    (en),
        .xin   (xin),
        .pairs (pairs)
    );

    for (genvar k = 0; k < `FIR_PAIRS; k++) begin : g_mult
        mult_man #(
            .M_W (`FIR_PAIR_W),
            .C_W (`FIR_COE_W),
            .COE (COE_TAB[k])
        ) u_mult (
            .clk      (clk),
            .rstn     (rstn),
            .data_rdy (pairs.valid),
            .mult1    (pairs.pair[k]),
            .res_rdy  (),
            .res      (prod_w[k])
        );
    end

    assign prod_rdy = g_mult[0].u_mult.res_rdy;     // lanes run in lockstep
    assign prods    = '{valid: prod_rdy, prod: prod_w};

    fir_sum_tree u_sum_tree (
        .clk   (clk),
        .rstn  (rstn),
        .prods (prods),
        .valid (valid),
        .yout  (yout)
    );

endmodule

// ==== tests/fir_guide_tb.sv ====
/* fir filter testbench */

`timescale 1ns/10ps

`include "fir_config.svh"

module fir_guide_tb
    import fir_pkg::*;
;

    localparam int CLK_PERIOD = 8;
    localparam int LATENCY    = 15;     // strobe edge to valid
    localparam int DRAIN      = 30;     // upper bound of one drain
    localparam int TOTAL_CYCLES = 5 + 16 + 32 + 300 + 400 + 50 + 5 + 50 + 6 * DRAIN;

    typedef struct packed {
        int     due;                    // cycle in which valid is expected
        fir_y_t y;
    } exp_t;

    logic   clk;
    logic   rstn;
    logic   en;
    fir_x_t xin;
    logic   valid;
    fir_y_t yout;

    integer seed = 32'h5e95;
    int     cyc = 0;
    int     value_errs = 0;
    int     timing_errs = 0;
    int     other_errs = 0;
    int     n_strobe = 0;
    int     n_valid = 0;
    fir_x_t hist [`FIR_TAPS];           // hist[0] is the newest sample
    exp_t   exp_q [$];
    exp_t   ent;
    fir_y_t got_q [$];                  // every output seen, for the fixed patterns

    int coe_tab [`FIR_PAIRS] = '{
        int'(`FIR_COE_0), int'(`FIR_COE_1), int'(`FIR_COE_2), int'(`FIR_COE_3),
        int'(`FIR_COE_4), int'(`FIR_COE_5), int'(`FIR_COE_6), int'(`FIR_COE_7)
    };

    fir_guide dut0 (
        .clk   (clk),
        .rstn  (rstn),
        .en    (en),
        .xin   (xin),
        .valid (valid),
        .yout  (yout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int model_output();
        int sum;
        sum = 0;
        for (int i = 0; i < `FIR_PAIRS; i++) begin
            sum += coe_tab[i] * (int'(hist[i]) + int'(hist[`FIR_TAPS-1-i]));
        end
        return sum;
    endfunction

    function automatic int tap_coe(input int j);
        return coe_tab[(j < `FIR_PAIRS) ? j : `FIR_TAPS - 1 - j];   // mirrored taps
    endfunction

    task automatic check_yout(input fir_y_t got, input fir_y_t exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED at %0t: %s, yout %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_timing(input int got_cyc, input int due_cyc);
        if (got_cyc != due_cyc) begin
            timing_errs++;
            $display("CHECK FAILED at %0t: valid in cycle %0d, due in cycle %0d",
                     $time, got_cyc, due_cyc);
        end
    endtask

    // model and monitor, sampled mid-cycle where everything is stable
    always @(negedge clk) begin
        if (!rstn) begin
            if (valid === 1'b1) begin
                other_errs++;
                $display("valid was high while reset was asserted at %0t", $time);
            end
            for (int i = 0; i < `FIR_TAPS; i++) hist[i] = '0;
            exp_q.delete();             // samples in flight are lost
        end else begin
            if (valid === 1'b1) begin
                n_valid++;
                got_q.push_back(yout);
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("valid at %0t with no output pending in the model", $time);
                end else begin
                    ent = exp_q.pop_front();
                    check_yout(yout, ent.y, "model output");
                    check_timing(cyc, ent.due);
                end
            end
            if (en === 1'b1) begin
                n_strobe++;
                for (int i = `FIR_TAPS - 1; i > 0; i--) hist[i] = hist[i-1];
                hist[0] = xin;
                ent.y   = fir_y_t'(model_output());
                ent.due = cyc + 1 + LATENCY;    // sampled at the next rising edge
                exp_q.push_back(ent);
            end
        end
    end

    task automatic drive_step(input logic e, input fir_x_t x);
        @(posedge clk);
        #1;
        en  = e;
        xin = x;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rstn = 1'b0;
        en   = 1'b0;
        xin  = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    task automatic drain_pipeline();
        int n;
        n = 0;
        drive_step(1'b0, '0);
        while (exp_q.size() != 0 && n < DRAIN - 3) begin
            @(posedge clk);
            n++;
        end
        repeat (2) @(posedge clk);
    endtask

    // ends a run that stalls
    initial begin
        #((TOTAL_CYCLES + 40) * CLK_PERIOD);
        $display("watchdog timeout, the test did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        en   = 1'b0;
        xin  = '0;
        apply_reset();

        // impulse gives the coefficient sequence
        got_q.delete();
        drive_step(1'b1, fir_x_t'(1000));
        repeat (15) drive_step(1'b1, '0);
        drain_pipeline();
        if (got_q.size() != `FIR_TAPS) begin
            other_errs++;
            $display("impulse gave %0d outputs instead of %0d", got_q.size(), `FIR_TAPS);
        end else begin
            for (int j = 0; j < `FIR_TAPS; j++) begin
                check_yout(got_q[j], fir_y_t'(1000 * tap_coe(j)), "impulse response");
            end
        end

        // full scale, pre-add must keep the carry
        got_q.delete();
        repeat (32) drive_step(1'b1, fir_x_t'(4095));
        drain_pipeline();
        if (got_q.size() == 0) begin
            other_errs++;
            $display("full scale input gave no output");
        end else begin
            check_yout(got_q[$], fir_y_t'(4095 * 2 * 1049), "full scale");
        end

        // back to back random samples
        repeat (300) drive_step(1'b1, fir_x_t'($random(seed)));
        drain_pipeline();

        // random gaps, about one strobe in three
        n_strobe = 0;
        n_valid  = 0;
        repeat (400) begin
            drive_step((($random(seed) & 32'h7fffffff) % 3) == 0, fir_x_t'($random(seed)));
        end
        drain_pipeline();
        if (n_strobe != n_valid) begin
            other_errs++;
            $display("%0d strobes gave %0d valid pulses", n_strobe, n_valid);
        end

        // reset in the middle of traffic
        repeat (50) drive_step(1'b1, fir_x_t'($random(seed)));
        apply_reset();
        repeat (50) drive_step(1'b1, fir_x_t'($random(seed)));
        drain_pipeline();

        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d expected outputs never arrived", exp_q.size());
        end
        $display("errors: value %0d, timing %0d, other %0d",
                 value_errs, timing_errs, other_errs);
        if (value_errs + timing_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/fir_pkg.sv
rtl/mult_man.sv
rtl/fir_tap_line.sv
rtl/fir_sum_tree.sv
rtl/fir_guide.sv
tests/fir_guide_tb.sv

// ==== Makefile ====
# Verilator simulation of the fir filter testbench

TOP = fir_guide_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
